/* run_sim.sh */
#!/usr/bin/env bash
# build and run the statistics monitor testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module stat_monitor_tb -Mdir obj_dir
./obj_dir/Vstat_monitor_tb | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"

/* tests/stat_monitor_tb.sv */
// directed testbench for the two-link statistics monitor
// drives both monitor taps, collects status frames and checks the reported counts
module stat_monitor_tb
    import stat_types_pkg::*, stat_report_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ns;

    localparam int   data_width      = 64;
    localparam int   keep_width      = data_width / 8;
    localparam int   clk_period      = 40;
    localparam int   period_cycles   = 64;
    localparam int   tick_per_period = period_cycles * keep_width;
    localparam tag_t tag_a_value     = 16'ha0a0;
    localparam tag_t tag_b_value     = 16'hb1b1;
    // six tests of about eight timer periods each
    localparam int   test_periods    = 48;

    logic clk, rst;
    logic [keep_width-1:0] monitor_a_keep, monitor_b_keep;
    logic monitor_a_valid, monitor_a_ready, monitor_a_last;
    logic monitor_b_valid, monitor_b_ready, monitor_b_last;
    tag_t tag_a, tag_b;
    interval_t interval;
    logic timer_enable;
    status_byte_t status_data;
    logic status_valid, status_ready, status_last;

    logic stall_en;
    int errors, checks, tests_run;
    int tally_bytes[2];
    int tally_frames[2];
    bit seen_first[2];

    // collected frames with one entry per complete report
    status_byte_t frame_bytes[$];
    time frame_start;
    tag_t rep_tag[$];
    count_t rep_tick[$], rep_bytes[$], rep_frames[$];
    time rep_start[$];

    stat_monitor_top #(.DATA_WIDTH(data_width)) UUT (
        .clk(clk), .rst(rst),
        .monitor_a_keep(monitor_a_keep), .monitor_a_valid(monitor_a_valid),
        .monitor_a_ready(monitor_a_ready), .monitor_a_last(monitor_a_last),
        .monitor_b_keep(monitor_b_keep), .monitor_b_valid(monitor_b_valid),
        .monitor_b_ready(monitor_b_ready), .monitor_b_last(monitor_b_last),
        .tag_a(tag_a), .tag_b(tag_b), .interval(interval), .timer_enable(timer_enable),
        .status_data(status_data), .status_valid(status_valid),
        .status_ready(status_ready), .status_last(status_last)
    );

    always #(clk_period / 2) clk = ~clk;

    // random back-pressure on the status stream
    always @(negedge clk) begin
        if (stall_en)
            status_ready <= ($urandom % 3) != 0;
        else
            status_ready <= 1'b1;
    end

    // big-endian field of the frame being collected
    function automatic count_t frame_field(input int offset, input int len);
        count_t value;
        value = '0;
        for (int i = 0; i < len; i++)
            value = (value << 8) | count_t'(frame_bytes[offset + i]);
        return value;
    endfunction

    always @(posedge clk) begin
        if (!rst && status_valid && status_ready) begin
            if (frame_bytes.size() == 0)
                frame_start = $time;
            frame_bytes.push_back(status_data);
            if (status_last) begin
                if (frame_bytes.size() != report_len) begin
                    $display("status frame ended after %0d bytes instead of %0d",
                             frame_bytes.size(), report_len);
                    errors++;
                end else begin
                    rep_tag.push_back(tag_t'(frame_field(tag_offset, tick_offset)));
                    rep_tick.push_back(frame_field(tick_offset, byte_offset - tick_offset));
                    rep_bytes.push_back(frame_field(byte_offset, frame_offset - byte_offset));
                    rep_frames.push_back(frame_field(frame_offset, report_len - frame_offset));
                    rep_start.push_back(frame_start);
                end
                frame_bytes.delete();
            end else if (frame_bytes.size() >= report_len) begin
                $display("status frame went past %0d bytes without last", report_len);
                errors++;
                frame_bytes.delete();
            end
        end
    end

    task automatic check_count(input count_t actual, input count_t expected, input string what);
        checks++;
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s is %0d, expected %0d",
                     $time, what, actual, expected);
            errors++;
        end
    endtask

    task automatic check_tag(input tag_t actual, input tag_t expected, input string what);
        checks++;
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h",
                     $time, what, actual, expected);
            errors++;
        end
    endtask

    task automatic set_tap(input int link, input logic [keep_width-1:0] keep,
            input logic valid, input logic ready, input logic last);
        if (link == 0) begin
            monitor_a_keep  = keep;
            monitor_a_valid = valid;
            monitor_a_ready = ready;
            monitor_a_last  = last;
        end else begin
            monitor_b_keep  = keep;
            monitor_b_valid = valid;
            monitor_b_ready = ready;
            monitor_b_last  = last;
        end
    endtask

    // random frames on one tap with a tally of bytes and frames per handshake
    task automatic drive_link(input int link, input int n_frames, input bit single_beat);
        int beats;
        int n_bytes;
        logic valid, ready, last;
        logic [keep_width-1:0] keep;
        for (int f = 0; f < n_frames; f++) begin
            beats = single_beat ? 1 : 1 + int'($urandom % 4);
            while (beats > 0) begin
                @(negedge clk);
                n_bytes = 1 + int'($urandom % keep_width);
                keep = {keep_width{1'b1}} >> (keep_width - n_bytes);
                valid = ($urandom % 4) != 0;
                ready = ($urandom % 4) != 0;
                last = (beats == 1);
                if (valid && ready) begin
                    tally_bytes[link] += n_bytes;
                    if (last)
                        tally_frames[link] += 1;
                    beats--;
                end
                set_tap(link, keep, valid, ready, last);
            end
        end
        @(negedge clk);
        set_tap(link, '0, 1'b0, 1'b0, 1'b0);
    endtask

    // the third report begun after the mark was triggered after the mark
    task automatic wait_reports(input time mark, input int needed);
        int seen_a, seen_b;
        do begin
            @(negedge clk);
            seen_a = 0;
            seen_b = 0;
            foreach (rep_tag[i]) begin
                if (rep_start[i] > mark && rep_tag[i] == tag_b)
                    seen_b++;
                else if (rep_start[i] > mark)
                    seen_a++;
            end
        end while (seen_a < needed || seen_b < needed);
        @(negedge clk);
    endtask

    task automatic check_reports(input bit check_order);
        int link;
        count_t sum_bytes[2];
        count_t sum_frames[2];
        sum_bytes = '{default: '0};
        sum_frames = '{default: '0};
        foreach (rep_tag[i]) begin
            link = (rep_tag[i] == tag_b) ? 1 : 0;
            if (link == 0)
                check_tag(rep_tag[i], tag_a, "report tag");
            // first report of the run spans the time since reset
            if (seen_first[link]) begin
                check_count(rep_tick[i] % count_t'(tick_per_period), '0, "ticks mod one period");
                check_count(count_t'(rep_tick[i] != '0), count_t'(1), "nonzero tick count");
            end
            seen_first[link] = 1'b1;
            sum_bytes[link] += rep_bytes[i];
            sum_frames[link] += rep_frames[i];
            if (check_order && i > 0)
                check_tag(rep_tag[i], (rep_tag[i-1] == tag_b) ? tag_a : tag_b, "round-robin order");
        end
        for (int l = 0; l < 2; l++) begin
            check_count(sum_bytes[l], count_t'(tally_bytes[l]),
                        $sformatf("link %s bytes", l ? "b" : "a"));
            check_count(sum_frames[l], count_t'(tally_frames[l]),
                        $sformatf("link %s frames", l ? "b" : "a"));
        end
    endtask

    task automatic run_test(input string name, input int frames_a, input int frames_b,
            input bit single_beat, input bit stall);
        int errors_before;
        time mark;
        errors_before = errors;
        @(negedge clk);
        rep_tag.delete();
        rep_tick.delete();
        rep_bytes.delete();
        rep_frames.delete();
        rep_start.delete();
        tally_bytes = '{0, 0};
        tally_frames = '{0, 0};
        stall_en = stall;
        fork
            drive_link(0, frames_a, single_beat);
            drive_link(1, frames_b, single_beat);
        join
        stall_en = 1'b0;
        mark = $time;
        wait_reports(mark, 3);
        check_reports(!stall);
        tests_run++;
        if (errors == errors_before)
            $display("test %0d, %s: ok", tests_run, name);
        else
            $display("test %0d, %s: %0d errors", tests_run, name, errors - errors_before);
    endtask

    initial begin
        #(test_periods * period_cycles * clk_period + 200 * clk_period);
        $display("watchdog timeout, the tests did not finish in time");
        $display("Test failed");
        $finish;
    end

    initial begin
        void'($urandom(71));
        clk = 1'b0;
        rst = 1'b1;
        set_tap(0, '0, 1'b0, 1'b0, 1'b0);
        set_tap(1, '0, 1'b0, 1'b0, 1'b0);
        tag_a = tag_a_value;
        tag_b = tag_b_value;
        interval = interval_t'(period_cycles);
        timer_enable = 1'b0;
        status_ready = 1'b1;
        stall_en = 1'b0;
        errors = 0;
        checks = 0;
        tests_run = 0;
        seen_first = '{1'b0, 1'b0};
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        timer_enable = 1'b1;

        run_test("idle links", 0, 0, 1'b0, 1'b0);
        run_test("byte and frame counting", 8, 0, 1'b0, 1'b0);
        run_test("both links active", 6, 9, 1'b0, 1'b0);
        run_test("frame integrity and fairness", 10, 10, 1'b0, 1'b0);
        run_test("single-beat frames", 12, 12, 1'b1, 1'b0);
        // stalls may skip triggers so it runs last
        run_test("back-pressure", 10, 10, 1'b0, 1'b1);

        $display("%0d tests run, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

/* verilog.f */
verilog/stat_types_pkg.sv
verilog/stat_report_pkg.sv
verilog/stat_trigger_timer.sv
verilog/axis_stat_counter.sv
verilog/stat_stream_arbiter.sv
verilog/stat_monitor_top.sv
tests/stat_monitor_tb.sv

/* verilog/axis_stat_counter.sv */
// statistics counter for one AXI4-Stream link, watched through a passive tap
// counts ticks, bytes and frames; a trigger snapshots the counts and sends
// them as a status frame on an 8-bit stream with a skid output stage
module axis_stat_counter
    import stat_types_pkg::*, stat_report_pkg::*;
#(
    parameter int DATA_WIDTH = 64
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [DATA_WIDTH/8-1:0]   monitor_keep,
    input  logic                      monitor_valid,
    input  logic                      monitor_ready,
    input  logic                      monitor_last,
    input  tag_t                      tag,
    input  logic                      trigger,
    output status_byte_t              out_data,
    output logic                      out_valid,
    input  logic                      out_ready,
    output logic                      out_last,
    output logic                      busy
);

    localparam int KEEP_WIDTH = DATA_WIDTH / 8;

    counter_state_t state, state_next;
    count_t         tick_count, tick_next;
    count_t         byte_count, byte_next;
    count_t         frame_count, frame_next;
    count_t         tick_snap, byte_snap, frame_snap;
    report_ptr_t    frame_ptr, ptr_next;
    logic           store_snap;

    // serializer side of the skid stage
    status_byte_t   ser_data;
    logic           ser_valid;
    logic           ser_last;
    logic           ser_ready;
    logic           ser_ready_early;

    status_byte_t   temp_data;
    logic           temp_valid;
    logic           temp_last;

    // keep masks are contiguous from bit 0, so the ones give the byte count
    function automatic count_t keep_bytes(input keep_mask_t keep);
        count_t n;
        n = '0;
        for (int i = 0; i < max_keep_width; i++) begin
            n = n + count_t'(keep[i]);
        end
        return n;
    endfunction

    // pick frame byte at ptr, msb first within each field
    function automatic status_byte_t report_byte(input report_ptr_t ptr, input tag_t t,
            input count_t ticks, input count_t bytes, input count_t frames);
        int idx;
        idx = int'(ptr);
        if (idx < tick_offset)
            return t[8*(tick_offset - 1 - idx) +: 8];
        else if (idx < byte_offset)
            return ticks[8*(byte_offset - 1 - idx) +: 8];
        else if (idx < frame_offset)
            return bytes[8*(frame_offset - 1 - idx) +: 8];
        else
            return frames[8*(report_len - 1 - idx) +: 8];
    endfunction

    always_comb begin
        state_next = state;
        tick_next  = tick_count;
        byte_next  = byte_count;
        frame_next = frame_count;
        ptr_next   = frame_ptr;
        store_snap = 1'b0;
        ser_data   = report_byte(frame_ptr, tag, tick_snap, byte_snap, frame_snap);
        ser_valid  = 1'b0;
        ser_last   = 1'b0;

        case (state)
            state_idle: begin
                if (trigger) begin
                    store_snap = 1'b1;
                    tick_next  = '0;
                    byte_next  = '0;
                    frame_next = '0;
                    ptr_next   = report_ptr_t'(tag_offset);
                    state_next = state_output;
                end
            end
            state_output: begin
                // triggers here are ignored, the live counts keep running
                if (ser_ready) begin
                    ser_valid = 1'b1;
                    if (int'(frame_ptr) == report_len - 1) begin
                        ser_last   = 1'b1;
                        state_next = state_idle;
                    end else begin
                        ptr_next = frame_ptr + 1'b1;
                    end
                end
            end
            default: state_next = state_idle;
        endcase

        // one tick is worth one beat of bytes
        tick_next = tick_next + count_t'(KEEP_WIDTH);
        if (monitor_valid && monitor_ready) begin
            byte_next = byte_next + keep_bytes(keep_mask_t'(monitor_keep));
            // frame counted on its last beat, single-beat frames included
            if (monitor_last) begin
                frame_next = frame_next + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= state_idle;
            tick_count  <= '0;
            byte_count  <= '0;
            frame_count <= '0;
            frame_ptr   <= '0;
            busy        <= 1'b0;
        end else begin
            state       <= state_next;
            tick_count  <= tick_next;
            byte_count  <= byte_next;
            frame_count <= frame_next;
            frame_ptr   <= ptr_next;
            busy        <= (state_next != state_idle);
        end
    end

    always_ff @(posedge clk) begin
        if (store_snap) begin
            tick_snap  <= tick_count;
            byte_snap  <= byte_count;
            frame_snap <= frame_count;
        end
    end

    // ready toward the serializer is registered, temp catches the extra byte
    assign ser_ready_early = out_ready || (!temp_valid && (!out_valid || !ser_valid));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid  <= 1'b0;
            temp_valid <= 1'b0;
            ser_ready  <= 1'b0;
        end else begin
            ser_ready <= ser_ready_early;
            if (ser_ready) begin
                if (out_ready || !out_valid) begin
                    out_valid <= ser_valid;
                end else begin
                    temp_valid <= ser_valid;
                end
            end else if (out_ready) begin
                out_valid  <= temp_valid;
                temp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ser_ready) begin
            if (out_ready || !out_valid) begin
                out_data <= ser_data;
                out_last <= ser_last;
            end else begin
                temp_data <= ser_data;
                temp_last <= ser_last;
            end
        end else if (out_ready) begin
            out_data <= temp_data;
            out_last <= temp_last;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        monitor_valid && monitor_ready |->
            ((monitor_keep & (monitor_keep + 1'b1)) == '0))
        else $error("non-contiguous keep mask on monitored link");

    assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
        else $error("status byte changed while stalled");

endmodule

/* verilog/stat_monitor_top.sv */
// traffic statistics for two AXI4-Stream links
// one timer triggers both counters, their reports share one status stream
module stat_monitor_top
    import stat_types_pkg::*;
#(
    parameter int DATA_WIDTH = 64
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [DATA_WIDTH/8-1:0] monitor_a_keep,
    input  logic                    monitor_a_valid,
    input  logic                    monitor_a_ready,
    input  logic                    monitor_a_last,
    input  logic [DATA_WIDTH/8-1:0] monitor_b_keep,
    input  logic                    monitor_b_valid,
    input  logic                    monitor_b_ready,
    input  logic                    monitor_b_last,
    input  tag_t                    tag_a,
    input  tag_t                    tag_b,
    input  interval_t               interval,
    input  logic                    timer_enable,
    output status_byte_t            status_data,
    output logic                    status_valid,
    input  logic                    status_ready,
    output logic                    status_last
);

    logic         stat_trigger;

    // report streams from the counters
    status_byte_t a_data, b_data;
    logic         a_valid, b_valid;
    logic         a_ready, b_ready;
    logic         a_last, b_last;

    stat_trigger_timer timer (
        .clk      (clk),
        .rst      (rst),
        .interval (interval),
        .enable   (timer_enable),
        .trigger  (stat_trigger)
    );

    axis_stat_counter #(.DATA_WIDTH(DATA_WIDTH)) counter_a (
        .clk(clk), .rst(rst),
        .monitor_keep(monitor_a_keep), .monitor_valid(monitor_a_valid),
        .monitor_ready(monitor_a_ready), .monitor_last(monitor_a_last),
        .tag(tag_a), .trigger(stat_trigger),
        .out_data(a_data), .out_valid(a_valid), .out_ready(a_ready), .out_last(a_last),
        .busy()
    );

    axis_stat_counter #(.DATA_WIDTH(DATA_WIDTH)) counter_b (
        .clk(clk), .rst(rst),
        .monitor_keep(monitor_b_keep), .monitor_valid(monitor_b_valid),
        .monitor_ready(monitor_b_ready), .monitor_last(monitor_b_last),
        .tag(tag_b), .trigger(stat_trigger),
        .out_data(b_data), .out_valid(b_valid), .out_ready(b_ready), .out_last(b_last),
        .busy()
    );

    stat_stream_arbiter arbiter (
        .clk(clk), .rst(rst),
        .a_data(a_data), .a_valid(a_valid), .a_ready(a_ready), .a_last(a_last),
        .b_data(b_data), .b_valid(b_valid), .b_ready(b_ready), .b_last(b_last),
        .out_data(status_data), .out_valid(status_valid),
        .out_ready(status_ready), .out_last(status_last)
    );

endmodule

/* verilog/stat_report_pkg.sv */
// byte layout of the status frame sent by each statistics counter
// fields go out most significant byte first, in offset order
package stat_report_pkg;

    // total frame length in bytes
    localparam int report_len = 14;

    // first byte of each field
    localparam int tag_offset   = 0;
    localparam int tick_offset  = 2;
    localparam int byte_offset  = 6;
    localparam int frame_offset = 10;

    // byte pointer into the frame
    typedef logic [$clog2(report_len)-1:0] report_ptr_t;

endpackage

/* verilog/stat_stream_arbiter.sv */
// merges two status streams into one, a whole frame at a time
// round-robin between frames so the source not served last goes first
module stat_stream_arbiter
    import stat_types_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  status_byte_t a_data,
    input  logic         a_valid,
    output logic         a_ready,
    input  logic         a_last,
    input  status_byte_t b_data,
    input  logic         b_valid,
    output logic         b_ready,
    input  logic         b_last,
    output status_byte_t out_data,
    output logic         out_valid,
    input  logic         out_ready,
    output logic         out_last
);

    // grant also remembers the source served last (0 = a, 1 = b)
    logic grant;
    logic locked;
    logic sel;
    logic frame_done;

    always_comb begin
        sel = grant;
        if (!locked) begin
            if (a_valid && b_valid) begin
                sel = ~grant;
            end else if (a_valid) begin
                sel = 1'b0;
            end else if (b_valid) begin
                sel = 1'b1;
            end
        end
    end

    // output mux
    assign out_data  = sel ? b_data : a_data;
    assign out_valid = sel ? b_valid : a_valid;
    assign out_last  = sel ? b_last : a_last;

    assign a_ready = out_ready && !sel;
    assign b_ready = out_ready && sel;

    assign frame_done = out_valid && out_ready && out_last;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // a goes first after reset
            grant  <= 1'b1;
            locked <= 1'b0;
        end else if (!locked) begin
            if (out_valid) begin
                grant <= sel;
                // single-byte frames finish in the cycle they start
                locked <= !frame_done;
            end
        end else if (frame_done) begin
            locked <= 1'b0;
        end
    end

    // once a source shows a byte it keeps the output until its last byte is taken
    assert property (@(posedge clk) disable iff (rst)
        out_valid && !(out_ready && out_last) |=> sel == $past(sel))
        else $error("arbiter grant changed in the middle of a frame");

endmodule

/* verilog/stat_trigger_timer.sv */
// periodic trigger for the statistics counters
// pulses trigger for one cycle every interval cycles while enable is high
module stat_trigger_timer
    import stat_types_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  interval_t interval,
    input  logic      enable,
    output logic      trigger
);

    interval_t count;
    logic      running;

    // pulse on the cycle where the down-counter has run out
    assign trigger = enable && running && (count == '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count   <= '0;
            running <= 1'b0;
        end else if (!enable) begin
            count   <= '0;
            running <= 1'b0;
        end else if (!running || count == '0) begin
            // first enabled cycle, or a period has just ended
            count   <= interval - 1'b1;
            running <= 1'b1;
        end else begin
            count <= count - 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        enable |-> interval != '0)
        else $error("trigger timer enabled with zero interval");

endmodule

/* verilog/stat_types_pkg.sv */
// common types for the link statistics monitor
// imported by the timer, the counters, the arbiter and the top level
package stat_types_pkg;

    // one statistics count (ticks, bytes or frames)
    typedef logic [31:0] count_t;

    // report tag, identifies the monitored link
    typedef logic [15:0] tag_t;

    // one byte of the status stream
    typedef logic [7:0] status_byte_t;

    // trigger period in clock cycles
    typedef logic [15:0] interval_t;

    // widest keep mask a monitored link may carry
    localparam int max_keep_width = 64;
    typedef logic [max_keep_width-1:0] keep_mask_t;

    typedef enum logic {
        state_idle,
        state_output
    } counter_state_t;

endpackage
